// File: compile.f
+incdir+include
rtl/rv_pkg.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/exe_stage.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/regfile.sv
rtl/cpu.sv
testbench/tb_cpu.sv

// File: include/rv_defs.svh
// core widths, reset pc, putch instruction word and a0 register index

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and address width
`define RV_XLEN 64

// instruction word width
`define RV_ILEN 32

// architectural registers
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 64'h0000_0000_8000_0000

// console instruction, prints low byte of a0
`define RV_PUTCH_INST 32'h0000_007b
`define RV_A0 5'd10

`endif

// File: rtl/cpu.sv
// cpu: top level wiring the five stages and the register file

module cpu import rv_pkg::*; (
  input  logic       clk,
  input  logic       i_rst,
  output logic       o_ibus_req,
  output xlen_t      o_ibus_addr,
  input  logic       i_ibus_ack,
  input  inst_t      i_ibus_rdata,
  output logic       o_dbus_req,
  output dbus_req_t  o_dbus,
  input  logic       i_dbus_ack,
  input  xlen_t      i_dbus_rdata,
  output logic       o_commit_valid,
  output commit_t    o_commit,
  output logic       o_putch_valid,
  output logic [7:0] o_putch_char
);

  // stage strobes and packets
  logic        fetched_req;
  logic        decoded_req;
  logic        executed_req;
  logic        memoryed_req;
  logic        writebacked_req;
  fetch_pkt_t  fetch_pkt;
  decode_pkt_t decode_pkt;
  exec_pkt_t   exec_pkt;
  exec_pkt_t   mem_pkt;
  redirect_t   redirect;

  // register file ports
  ridx_t rs1;
  ridx_t rs2;
  xlen_t rs1_data;
  xlen_t rs2_data;
  ridx_t rd;
  logic  rd_wen;
  xlen_t rd_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // stages

  if_stage if_stage_i (
    .clk(clk), .i_rst(i_rst),
    .i_writebacked_req(writebacked_req), .i_redirect(redirect),
    .o_ibus_req(o_ibus_req), .o_ibus_addr(o_ibus_addr),
    .i_ibus_ack(i_ibus_ack), .i_ibus_rdata(i_ibus_rdata),
    .o_fetched_req(fetched_req), .o_fetch(fetch_pkt)
  );

  id_stage id_stage_i (
    .clk(clk), .i_rst(i_rst),
    .i_fetched_req(fetched_req), .i_fetch(fetch_pkt),
    .o_rs1(rs1), .o_rs2(rs2), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_decoded_req(decoded_req), .o_decode(decode_pkt)
  );

  exe_stage exe_stage_i (
    .clk(clk), .i_rst(i_rst),
    .i_decoded_req(decoded_req), .i_decode(decode_pkt),
    .o_executed_req(executed_req), .o_exec(exec_pkt), .o_redirect(redirect)
  );

  mem_stage mem_stage_i (
    .clk(clk), .i_rst(i_rst),
    .i_executed_req(executed_req), .i_exec(exec_pkt),
    .o_dbus_req(o_dbus_req), .o_dbus(o_dbus),
    .i_dbus_ack(i_dbus_ack), .i_dbus_rdata(i_dbus_rdata),
    .o_memoryed_req(memoryed_req), .o_mem(mem_pkt)
  );

  wb_stage wb_stage_i (
    .clk(clk), .i_rst(i_rst),
    .i_memoryed_req(memoryed_req), .i_mem(mem_pkt),
    .o_rd(rd), .o_rd_wen(rd_wen), .o_rd_wdata(rd_wdata),
    .o_writebacked_req(writebacked_req),
    .o_commit_valid(o_commit_valid), .o_commit(o_commit),
    .o_putch_valid(o_putch_valid), .o_putch_char(o_putch_char)
  );

  regfile regfile_i (
    .clk(clk), .i_rst(i_rst),
    .i_rs1(rs1), .i_rs2(rs2), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .i_rd(rd), .i_rd_wen(rd_wen), .i_rd_wdata(rd_wdata)
  );

endmodule

// File: rtl/exe_stage.sv
// exe_stage: add/sub alu, address generation, branch compare and jump target

module exe_stage import rv_pkg::*; (
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_decoded_req,
  input  decode_pkt_t i_decode,
  output logic        o_executed_req,
  output exec_pkt_t   o_exec,
  output redirect_t   o_redirect
);

  xlen_t alu_res;
  xlen_t mem_addr;
  xlen_t result;
  logic  br_taken;
  logic  redir_taken;
  xlen_t redir_target;

  always_comb begin
    case (i_decode.alu_op)
      alu_add:    alu_res = i_decode.op_a + i_decode.op_b;
      alu_sub:    alu_res = i_decode.op_a - i_decode.op_b;
      alu_pass_b: alu_res = i_decode.op_b;
      default:    alu_res = i_decode.pc + xlen_t'(4);
    endcase
  end

  assign mem_addr = i_decode.op_a + i_decode.imm;

  // memory ops carry the address, putch carries a0
  assign result = (i_decode.mem_op != mem_none) ? mem_addr :
                  i_decode.is_putch             ? i_decode.op_a :
                                                  alu_res;

  always_comb begin
    case (i_decode.br_op)
      br_beq:  br_taken = (i_decode.op_a == i_decode.op_b);
      br_bne:  br_taken = (i_decode.op_a != i_decode.op_b);
      br_jal:  br_taken = 1'b1;
      default: br_taken = 1'b0;
    endcase
  end

  assign o_redirect.taken  = redir_taken;
  assign o_redirect.target = redir_target;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_executed_req <= 1'b0;
      redir_taken    <= 1'b0;
    end else begin
      o_executed_req <= i_decoded_req;
      redir_taken    <= i_decoded_req && br_taken;
    end
  end

  always_ff @(posedge clk) begin
    if (i_decoded_req) begin
      o_exec.pc         <= i_decode.pc;
      o_exec.inst       <= i_decode.inst;
      o_exec.result     <= result;
      o_exec.store_data <= i_decode.op_b;
      o_exec.rd         <= i_decode.rd;
      o_exec.rd_wen     <= i_decode.rd_wen;
      o_exec.mem_op     <= i_decode.mem_op;
      o_exec.is_putch   <= i_decode.is_putch;
      redir_target      <= i_decode.pc + i_decode.imm;
    end
  end

endmodule

// File: rtl/id_stage.sv
// id_stage: subset decoder, immediate generation and operand select

`include "rv_defs.svh"

module id_stage import rv_pkg::*; (
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_fetched_req,
  input  fetch_pkt_t  i_fetch,
  output ridx_t       o_rs1,
  output ridx_t       o_rs2,
  input  xlen_t       i_rs1_data,
  input  xlen_t       i_rs2_data,
  output logic        o_decoded_req,
  output decode_pkt_t o_decode
);

  inst_t       inst;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        is_putch;
  xlen_t       imm_i;
  xlen_t       imm_s;
  xlen_t       imm_b;
  xlen_t       imm_j;
  xlen_t       imm_u;
  decode_pkt_t dec;

  assign inst     = i_fetch.inst;
  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign is_putch = (inst == `RV_PUTCH_INST);

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};

  // putch reads a0 through the rs1 port
  assign o_rs1 = is_putch ? ridx_t'(`RV_A0) : inst[19:15];
  assign o_rs2 = inst[24:20];

  always_comb begin
    dec          = '0;
    dec.pc       = i_fetch.pc;
    dec.inst     = inst;
    dec.op_a     = i_rs1_data;
    dec.op_b     = i_rs2_data;
    dec.imm      = imm_i;
    dec.rd       = inst[11:7];
    dec.alu_op   = alu_add;
    dec.mem_op   = mem_none;
    dec.br_op    = br_none;
    dec.is_putch = is_putch;
    if (!is_putch) begin
      case (opcode)
        // addi
        7'b0010011: begin
          if (funct3 == 3'b000) begin
            dec.op_b   = imm_i;
            dec.rd_wen = 1'b1;
          end
        end
        // add, sub
        7'b0110011: begin
          if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
            dec.rd_wen = 1'b1;
          end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
            dec.alu_op = alu_sub;
            dec.rd_wen = 1'b1;
          end
        end
        // lui
        7'b0110111: begin
          dec.op_b   = imm_u;
          dec.alu_op = alu_pass_b;
          dec.rd_wen = 1'b1;
        end
        // ld
        7'b0000011: begin
          if (funct3 == 3'b011) begin
            dec.mem_op = mem_load;
            dec.rd_wen = 1'b1;
          end
        end
        // sd
        7'b0100011: begin
          if (funct3 == 3'b011) begin
            dec.imm    = imm_s;
            dec.mem_op = mem_store;
          end
        end
        // beq, bne
        7'b1100011: begin
          dec.imm = imm_b;
          if (funct3 == 3'b000) begin
            dec.br_op = br_beq;
          end else if (funct3 == 3'b001) begin
            dec.br_op = br_bne;
          end
        end
        // jal
        7'b1101111: begin
          dec.imm    = imm_j;
          dec.br_op  = br_jal;
          dec.alu_op = alu_link;
          dec.rd_wen = 1'b1;
        end
        default: begin
          // anything else commits as a no-op
          dec.rd_wen = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_decoded_req <= 1'b0;
    end else begin
      o_decoded_req <= i_fetched_req;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched_req) begin
      o_decode <= dec;
    end
  end

endmodule

// File: rtl/if_stage.sv
// if_stage: pc register, instruction bus request FSM and branch redirect

`include "rv_defs.svh"

module if_stage import rv_pkg::*; (
  input  logic       clk,
  input  logic       i_rst,
  input  logic       i_writebacked_req,
  input  redirect_t  i_redirect,
  output logic       o_ibus_req,
  output xlen_t      o_ibus_addr,
  input  logic       i_ibus_ack,
  input  inst_t      i_ibus_rdata,
  output logic       o_fetched_req,
  output fetch_pkt_t o_fetch
);

  fetch_state_e state;
  xlen_t        pc;
  logic         redir_taken;
  xlen_t        redir_target;
  xlen_t        next_pc;

  assign next_pc     = redir_taken ? redir_target : pc + xlen_t'(4);
  assign o_ibus_req  = (state == fetch_wait_ack);
  assign o_ibus_addr = pc;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state         <= fetch_idle;
      pc            <= `RV_RESET_PC;
      o_fetched_req <= 1'b0;
      redir_taken   <= 1'b0;
    end else begin
      o_fetched_req <= 1'b0;
      case (state)
        fetch_idle: begin
          state <= fetch_wait_ack;
        end
        fetch_wait_ack: begin
          if (i_ibus_ack) begin
            state         <= fetch_busy;
            o_fetched_req <= 1'b1;
          end
        end
        fetch_busy: begin
          // wait for commit, then fetch again straight away
          if (i_writebacked_req) begin
            state <= fetch_wait_ack;
            pc    <= next_pc;
          end
        end
        default: begin
          state <= fetch_idle;
        end
      endcase
      if (i_writebacked_req) begin
        redir_taken <= 1'b0;
      end else if (i_redirect.taken) begin
        redir_taken <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_redirect.taken) begin
      redir_target <= i_redirect.target;
    end
    if (o_ibus_req && i_ibus_ack) begin
      o_fetch.pc   <= pc;
      o_fetch.inst <= i_ibus_rdata;
    end
  end

endmodule

// File: rtl/mem_stage.sv
// mem_stage: data bus requests for ld/sd and load data return

module mem_stage import rv_pkg::*; (
  input  logic      clk,
  input  logic      i_rst,
  input  logic      i_executed_req,
  input  exec_pkt_t i_exec,
  output logic      o_dbus_req,
  output dbus_req_t o_dbus,
  input  logic      i_dbus_ack,
  input  xlen_t     i_dbus_rdata,
  output logic      o_memoryed_req,
  output exec_pkt_t o_mem
);

  logic is_mem;
  logic bus_done;

  assign is_mem   = (i_exec.mem_op != mem_none);
  assign bus_done = o_dbus_req && i_dbus_ack;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_dbus_req     <= 1'b0;
      o_memoryed_req <= 1'b0;
    end else begin
      o_memoryed_req <= 1'b0;
      if (i_executed_req) begin
        // non-memory ops go straight through
        if (is_mem) begin
          o_dbus_req <= 1'b1;
        end else begin
          o_memoryed_req <= 1'b1;
        end
      end else if (bus_done) begin
        o_dbus_req     <= 1'b0;
        o_memoryed_req <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // request fields held stable until ack

  always_ff @(posedge clk) begin
    if (i_executed_req) begin
      o_mem        <= i_exec;
      o_dbus.we    <= (i_exec.mem_op == mem_store);
      o_dbus.addr  <= i_exec.result;
      o_dbus.wdata <= i_exec.store_data;
    end else if (bus_done && o_mem.mem_op == mem_load) begin
      o_mem.result <= i_dbus_rdata;
    end
  end

endmodule

// File: rtl/regfile.sv
// regfile: 32 x 64-bit registers, two combinational reads, one write

`include "rv_defs.svh"

module regfile import rv_pkg::*; (
  input  logic  clk,
  input  logic  i_rst,
  input  ridx_t i_rs1,
  input  ridx_t i_rs2,
  output xlen_t o_rs1_data,
  output xlen_t o_rs2_data,
  input  ridx_t i_rd,
  input  logic  i_rd_wen,
  input  xlen_t i_rd_wdata
);

  xlen_t regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && i_rd != '0) begin
      regs[i_rd] <= i_rd_wdata;
    end
  end

  // x0 always reads zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: rtl/rv_pkg.sv
// rv_pkg: word typedefs, decode enums and stage/bus packet structs

`include "rv_defs.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] xlen_t;
  typedef logic [`RV_ILEN-1:0] inst_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] ridx_t;

  ////////////////////////////////////////////////////////////////////////////
  // decode controls

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_pass_b,
    alu_link
  } alu_op_e;

  typedef enum logic [1:0] {
    mem_none,
    mem_load,
    mem_store
  } mem_op_e;

  typedef enum logic [1:0] {
    br_none,
    br_beq,
    br_bne,
    br_jal
  } br_op_e;

  typedef enum logic [1:0] {
    fetch_idle,
    fetch_wait_ack,
    fetch_busy
  } fetch_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // packets between stages

  typedef struct packed {
    xlen_t pc;
    inst_t inst;
  } fetch_pkt_t;

  typedef struct packed {
    xlen_t   pc;
    inst_t   inst;
    xlen_t   op_a;
    xlen_t   op_b;
    xlen_t   imm;
    ridx_t   rd;
    logic    rd_wen;
    alu_op_e alu_op;
    mem_op_e mem_op;
    br_op_e  br_op;
    logic    is_putch;
  } decode_pkt_t;

  // result holds the alu value, the memory address or the load data
  typedef struct packed {
    xlen_t   pc;
    inst_t   inst;
    xlen_t   result;
    xlen_t   store_data;
    ridx_t   rd;
    logic    rd_wen;
    mem_op_e mem_op;
    logic    is_putch;
  } exec_pkt_t;

  typedef struct packed {
    logic  taken;
    xlen_t target;
  } redirect_t;

  // data bus request fields, 64-bit accesses only
  typedef struct packed {
    logic  we;
    xlen_t addr;
    xlen_t wdata;
  } dbus_req_t;

  typedef struct packed {
    xlen_t pc;
    inst_t inst;
    ridx_t rd;
    logic  rd_wen;
    xlen_t rd_wdata;
  } commit_t;

endpackage

// File: rtl/wb_stage.sv
// wb_stage: register write port, commit record and putch output

module wb_stage import rv_pkg::*; (
  input  logic      clk,
  input  logic      i_rst,
  input  logic      i_memoryed_req,
  input  exec_pkt_t i_mem,
  output ridx_t     o_rd,
  output logic      o_rd_wen,
  output xlen_t     o_rd_wdata,
  output logic      o_writebacked_req,
  output logic      o_commit_valid,
  output commit_t   o_commit,
  output logic      o_putch_valid,
  output logic [7:0] o_putch_char
);

  // write lands on the same edge the commit record is registered
  assign o_rd       = i_mem.rd;
  assign o_rd_wen   = i_memoryed_req && i_mem.rd_wen;
  assign o_rd_wdata = i_mem.result;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_writebacked_req <= 1'b0;
      o_commit_valid    <= 1'b0;
      o_putch_valid     <= 1'b0;
    end else begin
      o_writebacked_req <= i_memoryed_req;
      o_commit_valid    <= i_memoryed_req;
      o_putch_valid     <= i_memoryed_req && i_mem.is_putch;
    end
  end

  always_ff @(posedge clk) begin
    if (i_memoryed_req) begin
      o_commit.pc       <= i_mem.pc;
      o_commit.inst     <= i_mem.inst;
      o_commit.rd       <= i_mem.rd;
      o_commit.rd_wen   <= i_mem.rd_wen;
      o_commit.rd_wdata <= i_mem.result;
      o_putch_char      <= i_mem.result[7:0];
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_cpu -f compile.f -o tb_cpu_sim \
  && ./obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/tb_cpu.sv
// tb_cpu: directed tests, bus memory models, reference model and compare tasks

`include "rv_defs.svh"

module tb_cpu import rv_pkg::*; ();

  logic       clk;
  logic       i_rst;
  logic       o_ibus_req;
  xlen_t      o_ibus_addr;
  logic       i_ibus_ack;
  inst_t      i_ibus_rdata;
  logic       o_dbus_req;
  dbus_req_t  o_dbus;
  logic       i_dbus_ack;
  xlen_t      i_dbus_rdata;
  logic       o_commit_valid;
  commit_t    o_commit;
  logic       o_putch_valid;
  logic [7:0] o_putch_char;

  // bus side memories
  inst_t imem [64];
  xlen_t dmem [xlen_t];
  inst_t prog [$];

  // reference model state
  xlen_t m_regs [32];
  xlen_t m_pc;
  xlen_t m_dmem [xlen_t];

  int         errors;
  int         timeouts;
  int         commits;
  int         ibus_starts;
  int         ib_max;
  int         db_max;
  int         ib_wait;
  int         db_wait;
  logic       ib_pend;
  logic       db_pend;
  logic       rst_seen;
  xlen_t      ib_addr;
  dbus_req_t  db_snap;
  logic [7:0] putch_q [$];

  cpu cpu_i (
    .clk(clk), .i_rst(i_rst),
    .o_ibus_req(o_ibus_req), .o_ibus_addr(o_ibus_addr),
    .i_ibus_ack(i_ibus_ack), .i_ibus_rdata(i_ibus_rdata),
    .o_dbus_req(o_dbus_req), .o_dbus(o_dbus),
    .i_dbus_ack(i_dbus_ack), .i_dbus_rdata(i_dbus_rdata),
    .o_commit_valid(o_commit_valid), .o_commit(o_commit),
    .o_putch_valid(o_putch_valid), .o_putch_char(o_putch_char)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_ridx(input string name, input ridx_t got, input ridx_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got,
                            input logic [7:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoders

  function automatic inst_t enc_i(input logic [11:0] imm, input ridx_t rs1,
                                  input logic [2:0] f3, input ridx_t rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input ridx_t rs2, input ridx_t rs1,
                                  input ridx_t rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  function automatic inst_t enc_u(input logic [19:0] imm, input ridx_t rd);
    return {imm, rd, 7'h37};
  endfunction

  function automatic inst_t enc_s(input logic [11:0] imm, input ridx_t rs2, input ridx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23};
  endfunction

  function automatic inst_t enc_b(input logic [12:0] imm, input ridx_t rs2, input ridx_t rs1,
                                  input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] imm, input ridx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [5:0] imem_index(input xlen_t addr);
    xlen_t off;
    off = addr - `RV_RESET_PC;
    return off[7:2];
  endfunction

  // unwritten data words depend on the full address
  function automatic xlen_t fill_word(input xlen_t addr);
    return {addr[31:0], addr[63:32]} ^ 64'h5a5a_5a5a_a5a5_a5a5;
  endfunction

  function automatic xlen_t model_read(input xlen_t addr);
    if (m_dmem.exists(addr)) begin
      return m_dmem[addr];
    end
    return fill_word(addr);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  task automatic model_step(output commit_t e, output logic putch, output logic [7:0] ch);
    inst_t      w;
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      a;
    xlen_t      b;
    xlen_t      npc;
    xlen_t      val;
    logic       wen;
    w   = imem[imem_index(m_pc)];
    op  = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    a   = m_regs[w[19:15]];
    b   = m_regs[w[24:20]];
    npc = m_pc + 64'd4;
    val = '0;
    wen = 1'b0;
    putch = 1'b0;
    ch = 8'h00;
    if (w == `RV_PUTCH_INST) begin
      putch = 1'b1;
      ch = m_regs[10][7:0];
    end else begin
      case (op)
        7'h13: if (f3 == 3'd0) begin
          wen = 1'b1;
          val = a + {{52{w[31]}}, w[31:20]};
        end
        7'h33: if (f3 == 3'd0 && f7 == 7'h00) begin
          wen = 1'b1;
          val = a + b;
        end else if (f3 == 3'd0 && f7 == 7'h20) begin
          wen = 1'b1;
          val = a - b;
        end
        7'h37: begin
          wen = 1'b1;
          val = {{32{w[31]}}, w[31:12], 12'h000};
        end
        7'h03: if (f3 == 3'd3) begin
          wen = 1'b1;
          val = model_read(a + {{52{w[31]}}, w[31:20]});
        end
        7'h23: if (f3 == 3'd3) begin
          m_dmem[a + {{52{w[31]}}, w[31:25], w[11:7]}] = b;
        end
        7'h63: if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
          npc = m_pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        7'h6f: begin
          wen = 1'b1;
          val = m_pc + 64'd4;
          npc = m_pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        default: begin
        end
      endcase
    end
    e.pc       = m_pc;
    e.inst     = w;
    e.rd       = w[11:7];
    e.rd_wen   = wen;
    e.rd_wdata = val;
    if (wen && w[11:7] != 5'd0) begin
      m_regs[w[11:7]] = val;
    end
    m_pc = npc;
  endtask

  task automatic expect_dbus(output dbus_req_t e);
    inst_t w;
    xlen_t a;
    w = imem[imem_index(m_pc)];
    a = m_regs[w[19:15]];
    if (!((w[6:0] == 7'h03 || w[6:0] == 7'h23) && w[14:12] == 3'd3)) begin
      errors++;
      $display("data bus request for an instruction that is not ld or sd");
    end
    e.we = (w[6:0] == 7'h23);
    if (e.we) begin
      e.addr  = a + {{52{w[31]}}, w[31:25], w[11:7]};
      e.wdata = m_regs[w[24:20]];
    end else begin
      e.addr  = a + {{52{w[31]}}, w[31:20]};
      e.wdata = '0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitors and bus responders

  task automatic monitor_commit;
    commit_t    e;
    logic       putch;
    logic [7:0] ch;
    if (o_putch_valid && !(o_commit_valid && o_commit.inst == `RV_PUTCH_INST)) begin
      errors++;
      $display("putch output raised outside a putch commit");
    end
    if (o_commit_valid) begin
      model_step(e, putch, ch);
      check_xlen("o_commit.pc", o_commit.pc, e.pc);
      check_inst("o_commit.inst", o_commit.inst, e.inst);
      check_ridx("o_commit.rd", o_commit.rd, e.rd);
      check_flag("o_commit.rd_wen", o_commit.rd_wen, e.rd_wen);
      if (e.rd_wen && e.rd != 5'd0) begin
        check_xlen("o_commit.rd_wdata", o_commit.rd_wdata, e.rd_wdata);
      end
      if (putch) begin
        check_flag("o_putch_valid", o_putch_valid, 1'b1);
        check_byte("o_putch_char", o_putch_char, ch);
        putch_q.push_back(o_putch_char);
      end
      commits++;
    end
  endtask

  task automatic serve_ibus;
    i_ibus_ack = 1'b0;
    if (o_ibus_req) begin
      if (!ib_pend) begin
        ib_pend = 1'b1;
        ib_addr = o_ibus_addr;
        ib_wait = int'($urandom % (ib_max + 1));
        check_xlen("o_ibus_addr", o_ibus_addr, m_pc);
        if (ibus_starts != commits) begin
          errors++;
          $display("new instruction request before the previous one committed");
        end
        ibus_starts++;
      end else begin
        check_xlen("o_ibus_addr", o_ibus_addr, ib_addr);
      end
      if (ib_wait == 0) begin
        i_ibus_ack   = 1'b1;
        i_ibus_rdata = imem[imem_index(o_ibus_addr)];
        ib_pend      = 1'b0;
      end else begin
        ib_wait--;
      end
    end
  endtask

  task automatic serve_dbus;
    dbus_req_t e;
    i_dbus_ack = 1'b0;
    if (o_dbus_req) begin
      if (!db_pend) begin
        db_pend = 1'b1;
        db_snap = o_dbus;
        db_wait = int'($urandom % (db_max + 1));
        expect_dbus(e);
        check_flag("o_dbus.we", o_dbus.we, e.we);
        check_xlen("o_dbus.addr", o_dbus.addr, e.addr);
        if (e.we) begin
          check_xlen("o_dbus.wdata", o_dbus.wdata, e.wdata);
        end
      end else begin
        check_flag("o_dbus.we", o_dbus.we, db_snap.we);
        check_xlen("o_dbus.addr", o_dbus.addr, db_snap.addr);
        check_xlen("o_dbus.wdata", o_dbus.wdata, db_snap.wdata);
      end
      if (db_wait == 0) begin
        i_dbus_ack = 1'b1;
        db_pend    = 1'b0;
        if (o_dbus.we) begin
          dmem[o_dbus.addr] = o_dbus.wdata;
        end else if (dmem.exists(o_dbus.addr)) begin
          i_dbus_rdata = dmem[o_dbus.addr];
        end else begin
          i_dbus_rdata = fill_word(o_dbus.addr);
        end
      end else begin
        db_wait--;
      end
    end
  endtask

  always @(posedge clk) begin
    rst_seen = i_rst;
    #1;
    if (rst_seen) begin
      if (o_ibus_req || o_dbus_req) begin
        errors++;
        $display("bus request raised during reset");
      end
      ib_pend    = 1'b0;
      db_pend    = 1'b0;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
    end else begin
      monitor_commit();
      serve_ibus();
      serve_dbus();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test helpers

  // reset, load prog into memory and restart the model
  task automatic start_program;
    @(posedge clk);
    #1;
    i_rst = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < 64; i++) begin
      imem[i] = enc_i(12'(i), 5'd0, 3'd0, 5'd0, 7'h13);
    end
    foreach (prog[i]) begin
      imem[i] = prog[i];
    end
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    dmem.delete();
    m_dmem.delete();
    putch_q.delete();
    m_pc        = `RV_RESET_PC;
    commits     = 0;
    ibus_starts = 0;
    repeat (2) @(posedge clk);
    #1;
    i_rst = 1'b0;
  endtask

  task automatic wait_commits(input int n);
    int cyc;
    cyc = 0;
    while (commits < n && cyc < 4000) begin
      @(posedge clk);
      cyc++;
    end
    if (commits < n) begin
      timeouts++;
      $display("timeout: %0d of %0d instructions committed", commits, n);
    end
  endtask

  task automatic load_arith_program;
    prog.delete();
    prog.push_back(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
    prog.push_back(enc_i(12'hffd, 5'd0, 3'd0, 5'd2, 7'h13));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 5'd3));
    prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 5'd4));
    prog.push_back(enc_u(20'h12345, 5'd5));
    // x0 write, then read x0 back
    prog.push_back(enc_i(12'd7, 5'd1, 3'd0, 5'd0, 7'h13));
    prog.push_back(enc_r(7'h00, 5'd1, 5'd0, 5'd6));
    prog.push_back(32'hffff_ffff);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic test_arith;
    load_arith_program();
    start_program();
    wait_commits(8);
  endtask

  task automatic test_memory;
    prog.delete();
    prog.push_back(enc_i(12'h100, 5'd0, 3'd0, 5'd1, 7'h13));
    prog.push_back(enc_i(12'h5a5, 5'd0, 3'd0, 5'd2, 7'h13));
    prog.push_back(enc_u(20'habcde, 5'd3));
    prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 5'd2));
    prog.push_back(enc_s(12'd8, 5'd2, 5'd1));
    prog.push_back(enc_s(12'd16, 5'd1, 5'd1));
    prog.push_back(enc_i(12'd8, 5'd1, 3'd3, 5'd4, 7'h03));
    prog.push_back(enc_i(12'd16, 5'd1, 3'd3, 5'd5, 7'h03));
    prog.push_back(enc_r(7'h00, 5'd5, 5'd4, 5'd6));
    prog.push_back(enc_i(12'd24, 5'd1, 3'd3, 5'd7, 7'h03));
    start_program();
    wait_commits(10);
  endtask

  task automatic test_branches;
    prog.delete();
    prog.push_back(enc_i(12'd3, 5'd0, 3'd0, 5'd1, 7'h13));
    prog.push_back(enc_i(12'd3, 5'd0, 3'd0, 5'd2, 7'h13));
    // taken beq skips one word
    prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'd0));
    prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd3, 7'h13));
    prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'd1));
    prog.push_back(enc_i(12'd2, 5'd0, 3'd0, 5'd4, 7'h13));
    prog.push_back(enc_j(21'd8, 5'd5));
    prog.push_back(enc_i(12'd9, 5'd0, 3'd0, 5'd6, 7'h13));
    prog.push_back(enc_b(13'd8, 5'd0, 5'd1, 3'd0));
    prog.push_back(enc_b(13'h1ff8, 5'd0, 5'd1, 3'd1));
    start_program();
    wait_commits(10);
  endtask

  task automatic test_putch;
    prog.delete();
    prog.push_back(enc_i(12'h041, 5'd0, 3'd0, 5'd10, 7'h13));
    prog.push_back(`RV_PUTCH_INST);
    prog.push_back(enc_i(12'd1, 5'd10, 3'd0, 5'd10, 7'h13));
    prog.push_back(`RV_PUTCH_INST);
    start_program();
    wait_commits(4);
    if (putch_q.size() != 2) begin
      errors++;
      $display("expected 2 console characters, saw %0d", putch_q.size());
    end else begin
      check_byte("putch char 0", putch_q[0], 8'h41);
      check_byte("putch char 1", putch_q[1], 8'h42);
    end
  endtask

  task automatic test_ibus_stall;
    ib_max = 12;
    load_arith_program();
    start_program();
    wait_commits(8);
    ib_max = 4;
  endtask

  initial begin
    i_rst        = 1'b1;
    i_ibus_ack   = 1'b0;
    i_ibus_rdata = '0;
    i_dbus_ack   = 1'b0;
    i_dbus_rdata = '0;
    errors       = 0;
    timeouts     = 0;
    commits      = 0;
    ibus_starts  = 0;
    ib_max       = 4;
    db_max       = 4;
    ib_pend      = 1'b0;
    db_pend      = 1'b0;
    m_pc         = `RV_RESET_PC;
    void'($urandom(32'he927));
    test_arith();
    test_memory();
    test_branches();
    test_putch();
    test_ibus_stall();
    $display("checks done, errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
